/* Makefile */
VERILATOR ?= verilator
TOP       ?= note_recognizer_tb
FILELIST  ?= note_recognizer.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* hdl/match_reporter.sv */
module match_reporter
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic [note_pkg::N_MELODIES-1:0] i_recognized,
    output logic                            o_match,
    output logic [note_pkg::MATCH_ID_W-1:0] o_match_id
);

    import note_pkg::*;

    logic [N_MELODIES-1:0] prev_rec;
    logic [N_MELODIES-1:0] rose;        // Newly recognized this cycle
    logic [MATCH_ID_W-1:0] low_id;

    assign rose = i_recognized & ~prev_rec;

    always_comb
    begin
        low_id = '0;
        for (int i = N_MELODIES - 1; i >= 0; i--)
        begin
            if (rose[i])
                low_id = MATCH_ID_W'(i);
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            prev_rec   <= '0;
            o_match    <= 1'b0;
            o_match_id <= '0;
        end
        else
        begin
            prev_rec <= i_recognized;
            o_match  <= |rose;          // One cycle per rise
            if (|rose)
                o_match_id <= low_id;
        end
    end

endmodule

/* hdl/melody_matcher.sv */
module melody_matcher
#(
    parameter int MELODY = 0
)
(
    input  logic                        clk,
    input  logic                        reset,
    input  note_pkg::note_t             i_note,
    output logic [note_pkg::STEP_W-1:0] o_step,
    output logic                        o_recognized
);

    import note_pkg::*;

    localparam int LEN = MELODY_LEN[MELODY];

    note_t expected;

    // Nothing left to match once recognized
    assign expected = (o_step < STEP_W'(LEN)) ? MELODY_NOTES[MELODY][o_step] : NOTE_NONE;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            o_step <= '0;
        else if (o_step != RECOGNIZED && i_note == expected)
        begin
            if (o_step == STEP_W'(LEN - 1))
                o_step <= RECOGNIZED;   // Last note heard
            else
                o_step <= o_step + 1'b1;
        end
    end

    assign o_recognized = (o_step == RECOGNIZED);

endmodule

/* hdl/note_classifier.sv */
module note_classifier
(
    input  logic [note_pkg::PERIOD_W-1:0] i_period,
    output note_pkg::note_t               o_raw_note
);

    import note_pkg::*;

    logic [N_NOTES-1:0] hit;

    // ----------------------------------------
    // Window checks over three octaves per note
    // ----------------------------------------

    for (genvar n = 0; n < N_NOTES; n++)
    begin : g_note
        logic [2:0] oct_hit;

        for (genvar k = 0; k < 3; k++)
        begin : g_oct
            localparam logic [PERIOD_W-1:0] LO = period_bound(FREQ_100[n], 1 << k, WIN_LO_PCT);
            localparam logic [PERIOD_W-1:0] HI = period_bound(FREQ_100[n], 1 << k, WIN_HI_PCT);

            assign oct_hit[k] = (i_period > LO) && (i_period < HI);
        end

        assign hit[n] = |oct_hit;
    end

    // ----------------------------------------
    // Priority encode with the lowest note winning
    // ----------------------------------------

    always_comb
    begin
        o_raw_note = NOTE_NONE;
        for (int n = N_NOTES - 1; n >= 0; n--)
        begin
            if (hit[n])
                o_raw_note = note_t'(n + 1);
        end
    end

endmodule

/* hdl/note_filter.sv */
module note_filter
(
    input  logic            clk,
    input  logic            reset,
    input  note_pkg::note_t i_raw_note,
    output note_pkg::note_t o_note
);

    import note_pkg::*;

    note_t                  d_note;     // Raw note delayed by one cycle
    logic [STABLE_BITS-1:0] run_cnt;    // Clocks without a change

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            d_note  <= NOTE_NONE;
            run_cnt <= '0;
            o_note  <= NOTE_NONE;
        end
        else
        begin
            d_note <= i_raw_note;

            if (i_raw_note == d_note)
                run_cnt <= run_cnt + 1'b1;
            else
                run_cnt <= '0;

            // Accept the note once stable long enough
            if (&run_cnt)
                o_note <= d_note;
        end
    end

endmodule

/* hdl/note_pkg.sv */
package note_pkg;

    // ----------------------------------------
    // Notes
    // ----------------------------------------

    typedef enum logic [3:0]
    {
        NOTE_NONE,
        NOTE_C,
        NOTE_CS,
        NOTE_D,
        NOTE_DS,
        NOTE_E,
        NOTE_F,
        NOTE_FS,
        NOTE_G,
        NOTE_GS,
        NOTE_A,
        NOTE_AS,
        NOTE_B
    } note_t;

    localparam int N_NOTES = 12;

    // Base octave in hundredths of a hertz
    localparam int FREQ_100 [N_NOTES] = '{
        26163, 27718, 29366, 31113, 32963, 34923,
        36999, 39200, 41530, 44000, 46616, 49388
    };

    // ----------------------------------------
    // Sampling and timing
    // ----------------------------------------

    localparam int                  SAMPLE_W    = 16;
    localparam logic [SAMPLE_W-1:0] THRESHOLD   = 16'h1100;
    localparam int                  PERIOD_W    = 20;       // Saturates at all ones
    localparam int                  CLK_HZ      = 1_000_000;
    localparam int                  WIN_LO_PCT  = 96;
    localparam int                  WIN_HI_PCT  = 104;
    localparam int                  STABLE_BITS = 10;       // 18 at 50 MHz

    // Period in clocks at octave multiple mult scaled by pct percent
    // Division before scaling rounds the window edges down
    function automatic logic [PERIOD_W-1:0] period_bound(input int f_100, input int mult,
                                                         input int pct);
        longint base;
        base = longint'(CLK_HZ) * 100 / (f_100 * mult);
        return PERIOD_W'(base * pct / 100);
    endfunction

    // ----------------------------------------
    // Melodies
    // ----------------------------------------

    localparam int                N_MELODIES = 3;
    localparam int                MAX_LEN    = 12;
    localparam int                STEP_W     = 4;
    localparam logic [STEP_W-1:0] RECOGNIZED = 4'hF;
    localparam int                MATCH_ID_W = 2;

    localparam int MELODY_LEN [N_MELODIES] = '{5, 9, 12};

    localparam note_t MELODY_NOTES [N_MELODIES][MAX_LEN] = '{
        '{NOTE_C, NOTE_A, NOTE_D, NOTE_C, NOTE_A, NOTE_NONE,        // Simple sequence
          NOTE_NONE, NOTE_NONE, NOTE_NONE, NOTE_NONE, NOTE_NONE, NOTE_NONE},
        '{NOTE_E, NOTE_DS, NOTE_E, NOTE_DS, NOTE_E, NOTE_B,         // Fur Elise
          NOTE_D, NOTE_C, NOTE_A, NOTE_NONE, NOTE_NONE, NOTE_NONE},
        '{NOTE_G, NOTE_C, NOTE_DS, NOTE_D, NOTE_C, NOTE_DS,         // Godfather
          NOTE_C, NOTE_D, NOTE_C, NOTE_GS, NOTE_AS, NOTE_G}
    };

endpackage

/* hdl/note_recognizer.sv */
module note_recognizer
(
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic [note_pkg::SAMPLE_W-1:0]                     i_sample,
    output note_pkg::note_t                                   o_note,
    output logic [note_pkg::N_MELODIES*note_pkg::STEP_W-1:0] o_steps,
    output logic [note_pkg::N_MELODIES-1:0]                   o_recognized,
    output logic                                              o_match,
    output logic [note_pkg::MATCH_ID_W-1:0]                   o_match_id
);

    import note_pkg::*;

    logic [PERIOD_W-1:0] period;
    note_t               raw_note;

    // ----------------------------------------
    // Pitch detection
    // ----------------------------------------

    period_meter u_meter
    (
        .clk      (clk),
        .reset    (reset),
        .i_sample (i_sample),
        .o_period (period)
    );

    note_classifier u_classifier
    (
        .i_period   (period),
        .o_raw_note (raw_note)
    );

    note_filter u_filter
    (
        .clk        (clk),
        .reset      (reset),
        .i_raw_note (raw_note),
        .o_note     (o_note)
    );

    // ----------------------------------------
    // One matcher per melody
    // ----------------------------------------

    for (genvar m = 0; m < N_MELODIES; m++)
    begin : g_matcher
        melody_matcher #(.MELODY(m)) u_matcher
        (
            .clk          (clk),
            .reset        (reset),
            .i_note       (o_note),
            .o_step       (o_steps[m*STEP_W +: STEP_W]),
            .o_recognized (o_recognized[m])
        );
    end

    match_reporter u_reporter
    (
        .clk          (clk),
        .reset        (reset),
        .i_recognized (o_recognized),
        .o_match      (o_match),
        .o_match_id   (o_match_id)
    );

endmodule

/* hdl/period_meter.sv */
module period_meter
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic [note_pkg::SAMPLE_W-1:0] i_sample,
    output logic [note_pkg::PERIOD_W-1:0] o_period
);

    import note_pkg::*;

    logic [SAMPLE_W-1:0] prev_sample;
    logic [PERIOD_W-1:0] counter;
    logic                crossing;

    // Rising crossing of the threshold
    assign crossing = (i_sample >= THRESHOLD) && (prev_sample < THRESHOLD);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            prev_sample <= '0;
            counter     <= '0;
            o_period    <= '0;
        end
        else
        begin
            prev_sample <= i_sample;

            if (crossing)
            begin
                o_period <= counter;    // Clocks since last crossing
                counter  <= '0;
            end
            else if (counter != '1)     // Hold at max on silence
            begin
                counter <= counter + 1'b1;
            end
        end
    end

endmodule

/* note_recognizer.f */
hdl/note_pkg.sv
hdl/period_meter.sv
hdl/note_classifier.sv
hdl/note_filter.sv
hdl/melody_matcher.sv
hdl/match_reporter.sv
hdl/note_recognizer.sv
test/tb_clock.sv
test/tb_monitor.sv
test/note_recognizer_checker.sv
test/note_recognizer_tb.sv

/* test/note_recognizer_checker.sv */
module note_recognizer_checker
(
    input logic                                             clk,
    input logic                                             reset,
    input logic                                             o_match,
    input logic [note_pkg::MATCH_ID_W-1:0]                  o_match_id,
    input logic [note_pkg::N_MELODIES-1:0]                  o_recognized,
    input logic [note_pkg::N_MELODIES*note_pkg::STEP_W-1:0] o_steps
);

    import note_pkg::*;

    int assert_fails = 0;

    // Match is a single-cycle pulse
    match_pulse: assert property (@(posedge clk) disable iff (reset) o_match |=> !o_match)
        else
        begin
            $error("o_match held longer than one cycle");
            assert_fails++;
        end

    // Reported id names a melody that is recognized
    match_id_range: assert property (@(posedge clk) disable iff (reset)
                                     o_match |-> (o_match_id < N_MELODIES)
                                                 && o_recognized[o_match_id])
        else
        begin
            $error("o_match_id out of range or not recognized");
            assert_fails++;
        end

    for (genvar m = 0; m < N_MELODIES; m++)
    begin : g_step
        step_range: assert property (@(posedge clk) disable iff (reset)
            (o_steps[m*STEP_W +: STEP_W] <= MELODY_LEN[m])
            || (o_steps[m*STEP_W +: STEP_W] == RECOGNIZED))
            else
            begin
                $error("Step of melody %0d out of range", m);
                assert_fails++;
            end
    end

endmodule

bind note_recognizer note_recognizer_checker u_checker (.*);

/* test/note_recognizer_tb.sv */
module note_recognizer_tb;

    import note_pkg::*;

    typedef struct packed
    {
        note_t      tone;       // Tone played
        logic [1:0] div;        // Frequency divider with 2 for half
        note_t      exp_note;
    } entry_t;

    localparam int N_ENTRIES    = 30;
    localparam int NOTE_TIMEOUT = 8;    // Periods
    localparam int REC_TIMEOUT  = 5000; // Cycles

    // ----------------------------------------
    // Stimulus table
    // ----------------------------------------
    localparam entry_t STIM [N_ENTRIES] = '{
        '{NOTE_C,  2'd1, NOTE_C},  '{NOTE_A,  2'd1, NOTE_A},  '{NOTE_E,  2'd1, NOTE_E},
        '{NOTE_D,  2'd1, NOTE_D},  '{NOTE_C,  2'd1, NOTE_C},  '{NOTE_A,  2'd1, NOTE_A},
        '{NOTE_C,  2'd2, NOTE_NONE},                            // Below every window
        '{NOTE_G,  2'd1, NOTE_G},  '{NOTE_DS, 2'd1, NOTE_DS}, '{NOTE_C,  2'd1, NOTE_C},
        '{NOTE_E,  2'd1, NOTE_E},  '{NOTE_DS, 2'd1, NOTE_DS}, '{NOTE_E,  2'd1, NOTE_E},
        '{NOTE_D,  2'd1, NOTE_D},  '{NOTE_B,  2'd1, NOTE_B},  '{NOTE_C,  2'd1, NOTE_C},
        '{NOTE_D,  2'd1, NOTE_D},  '{NOTE_DS, 2'd1, NOTE_DS}, '{NOTE_C,  2'd1, NOTE_C},
        '{NOTE_A,  2'd1, NOTE_A},  '{NOTE_D,  2'd1, NOTE_D},  '{NOTE_C,  2'd1, NOTE_C},
        '{NOTE_GS, 2'd1, NOTE_GS}, '{NOTE_AS, 2'd1, NOTE_AS}, '{NOTE_G,  2'd1, NOTE_G},
        '{NOTE_C,  2'd1, NOTE_C},  '{NOTE_A,  2'd1, NOTE_A},  '{NOTE_D,  2'd1, NOTE_D},
        '{NOTE_C,  2'd1, NOTE_C},  '{NOTE_A,  2'd1, NOTE_A}   // Replay of melody 0
    };

    logic                           clk;
    logic                           reset;
    logic [SAMPLE_W-1:0]            sample;
    note_t                          note;
    logic [N_MELODIES*STEP_W-1:0]   steps;
    logic [N_MELODIES-1:0]          recognized;
    logic                           match;
    logic [MATCH_ID_W-1:0]          match_id;
    int                             tone_period;
    note_t                          tone_exp;
    logic                           tone_done;
    logic                           final_chk;
    int                             mon_errors;
    int                             errors;
    int                             seed;

    tb_clock u_clock (.clk(clk), .reset(reset));

    note_recognizer dut
    (
        .clk          (clk),
        .reset        (reset),
        .i_sample     (sample),
        .o_note       (note),
        .o_steps      (steps),
        .o_recognized (recognized),
        .o_match      (match),
        .o_match_id   (match_id)
    );

    tb_monitor u_monitor
    (
        .clk(clk), .reset(reset), .i_note(note), .i_steps(steps),
        .i_recognized(recognized), .i_match(match), .i_match_id(match_id),
        .i_tone_period(tone_period), .i_tone_exp(tone_exp), .i_tone_done(tone_done),
        .i_final(final_chk), .o_errors(mon_errors)
    );

    // High half first so each crossing starts a full period
    task automatic play_period(input int p);
        for (int c = 0; c < p; c++)
        begin
            @(posedge clk);
            sample <= (c < p / 2) ? 16'hFFFF : 16'h0000;
        end
    endtask

    task automatic play_entry(input int i);
        int p;
        int waited;
        int extra;
        p = CLK_HZ * 100 * STIM[i].div / FREQ_100[STIM[i].tone - 1];
        tone_period = p;
        tone_exp    = STIM[i].exp_note;
        play_period(p);
        play_period(p);
        waited = 0;
        while (waited < NOTE_TIMEOUT)
        begin
            @(negedge clk);
            if (note == STIM[i].exp_note)
                break;
            play_period(p);
            waited++;
        end
        if (note != STIM[i].exp_note)
        begin
            $display("Timeout waiting for o_note to settle on entry %0d", i);
            errors++;
        end
        extra = 3 + ($random(seed) & 3);
        repeat (extra) play_period(p);
        @(posedge clk) tone_done <= 1'b1;
        @(posedge clk) tone_done <= 1'b0;
    endtask

    initial
    begin
        int waited;
        sample    = '0;
        tone_done = 1'b0;
        final_chk = 1'b0;
        tone_period = 0;
        tone_exp  = NOTE_NONE;
        errors    = 0;
        seed      = 32'h73bcd177;
        waited    = 0;
        while (reset !== 1'b0 && waited < 100)
        begin
            @(posedge clk);
            waited++;
        end
        if (reset !== 1'b0)
        begin
            $display("Timeout waiting for reset to be released");
            errors++;
        end
        for (int i = 0; i < N_ENTRIES; i++)
            play_entry(i);

        waited = 0;
        while (recognized != '1 && waited < REC_TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        if (recognized != '1)
        begin
            $display("Timeout waiting for all melodies to be recognized");
            errors++;
        end
        @(posedge clk) final_chk <= 1'b1;
        @(posedge clk) final_chk <= 1'b0;
        @(posedge clk);
        errors = errors + dut.u_checker.assert_fails;
        $display("Errors: testbench %0d, monitor %0d", errors, mon_errors);
        if (errors == 0 && mon_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* test/tb_clock.sv */
module tb_clock
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk   = 1'b0;
        reset = 1'b1;
    end

    always #2 clk = ~clk;   // Period 4

    initial
    begin
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* test/tb_monitor.sv */
module tb_monitor
(
    input  logic                                             clk,
    input  logic                                             reset,
    input  note_pkg::note_t                                  i_note,
    input  logic [note_pkg::N_MELODIES*note_pkg::STEP_W-1:0] i_steps,
    input  logic [note_pkg::N_MELODIES-1:0]                  i_recognized,
    input  logic                                             i_match,
    input  logic [note_pkg::MATCH_ID_W-1:0]                  i_match_id,
    input  int                                               i_tone_period,
    input  note_pkg::note_t                                  i_tone_exp,
    input  logic                                             i_tone_done,
    input  logic                                             i_final,
    output int                                               o_errors
);

    import note_pkg::*;

    logic [STEP_W-1:0]     model_step [N_MELODIES];
    logic [N_MELODIES-1:0] prev_rec;
    logic [N_MELODIES-1:0] now_rec;
    logic [N_MELODIES-1:0] rose_m;
    logic                  exp_match;
    logic [MATCH_ID_W-1:0] exp_id;
    int                    match_cnt [N_MELODIES];
    logic                  after_reset;
    logic [STEP_W-1:0]     got_step;
    note_t                 want;

    // Window rule over three octaves with the lowest note first
    function automatic note_t expected_note(input int period);
        longint base;
        longint lo;
        longint hi;
        expected_note = NOTE_NONE;
        for (int n = N_NOTES - 1; n >= 0; n--)
        begin
            for (int m = 1; m <= 4; m = m * 2)
            begin
                base = longint'(CLK_HZ) * 100 / (FREQ_100[n] * m);
                lo   = base * WIN_LO_PCT / 100;
                hi   = base * WIN_HI_PCT / 100;
                if (period > lo && period < hi)
                    expected_note = note_t'(n + 1);
            end
        end
    endfunction

    always @(negedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int m = 0; m < N_MELODIES; m++)
            begin
                model_step[m] = '0;
                match_cnt[m]  = 0;
            end
            prev_rec    = '0;
            exp_match   = 1'b0;
            exp_id      = '0;
            after_reset = 1'b1;
            o_errors    = 0;
        end
        else
        begin
            if (after_reset && i_note !== NOTE_NONE)
            begin
                $display("[FAIL] %0t o_note got %s expected NOTE_NONE", $time, i_note.name());
                o_errors++;
            end
            after_reset = 1'b0;

            // ----------------------------------------
            // Cycle-exact step and report checks
            // ----------------------------------------
            for (int m = 0; m < N_MELODIES; m++)
            begin
                got_step = i_steps[m*STEP_W +: STEP_W];
                if (got_step !== model_step[m])
                begin
                    $display("[FAIL] %0t o_steps[%0d] got %0d expected %0d",
                             $time, m, got_step, model_step[m]);
                    o_errors++;
                end
                if (i_recognized[m] !== (model_step[m] == RECOGNIZED))
                begin
                    $display("[FAIL] %0t o_recognized[%0d] got %b expected %b",
                             $time, m, i_recognized[m], model_step[m] == RECOGNIZED);
                    o_errors++;
                end
            end
            if (i_match !== exp_match)
            begin
                $display("[FAIL] %0t o_match got %b expected %b", $time, i_match, exp_match);
                o_errors++;
            end
            else if (exp_match && i_match_id !== exp_id)
            begin
                $display("[FAIL] %0t o_match_id got %0d expected %0d",
                         $time, i_match_id, exp_id);
                o_errors++;
            end
            if (i_match === 1'b1 && i_match_id < N_MELODIES)
                match_cnt[i_match_id]++;

            // Predict next cycle's report
            for (int m = 0; m < N_MELODIES; m++)
                now_rec[m] = (model_step[m] == RECOGNIZED);
            rose_m    = now_rec & ~prev_rec;
            exp_match = |rose_m;
            for (int m = N_MELODIES - 1; m >= 0; m--)
                if (rose_m[m])
                    exp_id = MATCH_ID_W'(m);
            prev_rec = now_rec;

            // Step rule for the coming edge
            for (int m = 0; m < N_MELODIES; m++)
            begin
                if (model_step[m] != RECOGNIZED
                    && i_note == MELODY_NOTES[m][model_step[m]])
                begin
                    if (model_step[m] == STEP_W'(MELODY_LEN[m] - 1))
                        model_step[m] = RECOGNIZED;
                    else
                        model_step[m] = model_step[m] + 1'b1;
                end
            end

            if (i_tone_done)
            begin
                want = expected_note(i_tone_period - 1);   // Counter restarts at zero
                if (want != i_tone_exp)
                begin
                    $display("Stimulus table entry disagrees with the window rule at %0t",
                             $time);
                    o_errors++;
                end
                if (i_note !== want)
                begin
                    $display("[FAIL] %0t o_note got %s expected %s",
                             $time, i_note.name(), want.name());
                    o_errors++;
                end
            end

            if (i_final)
            begin
                for (int m = 0; m < N_MELODIES; m++)
                begin
                    if (match_cnt[m] != 1)
                    begin
                        $display("Melody %0d was reported %0d times instead of once",
                                 m, match_cnt[m]);
                        o_errors++;
                    end
                end
            end
        end
    end

endmodule
